// File: build.f
hw/pci_master_pkg.sv
hw/pci_master_fsm.sv
hw/pci_beat_counters.sv
hw/pci_wdata_buffer.sv
hw/pci_adio_mux.sv
hw/pci_master_top.sv
verification/pci_core_model.sv
verification/pci_master_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=pci_master_sim

verilator --binary --timing --assert --top-module pci_master_tb \
	-f build.f -Mdir obj_dir -o "$BIN"
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Errors found" "$LOG"; then
	exit 1
fi
exit 0

// File: verification/pci_master_tb.sv
`timescale 1ns/1ps

module pci_master_tb;

	logic clk;
	logic rst;
	pci_master_pkg::pci_cmd_t wcmd;
	pci_master_pkg::pci_cmd_t rcmd;
	logic wcmd_valid;
	logic rcmd_valid;
	logic wcmd_ready;
	logic rcmd_ready;
	pci_master_pkg::pci_resp_t wresp;
	pci_master_pkg::pci_resp_t rresp;
	logic wresp_valid;
	logic rresp_valid;
	logic wresp_ready;
	logic rresp_ready;
	logic [31:0] rdata_din;
	logic rdata_valid;
	pci_master_pkg::wbuf_wr_t wbuf;
	logic [7:0] cacheline_size;
	pci_master_pkg::core_stat_t core;
	logic [31:0] adio_in;
	logic [31:0] adio_out;
	logic request;
	logic request_hold;
	logic [3:0] m_cbe;
	logic m_wrdn;
	logic complete;
	logic m_ready;
	logic [8:0] burst_beats;
	logic [8:0] disc_after;
	logic no_target;

	int seed = 32'h6b13ca88;
	int errors = 0;
	int checks = 0;
	int tests_run = 0;
	int wresp_cnt = 0;
	int rresp_cnt = 0;
	pci_master_pkg::pci_resp_t last_wresp;
	pci_master_pkg::pci_resp_t last_rresp;
	logic [31:0] rd_words [$]; // every read beat seen on rdata
	logic [31:0] wwords [$]; // words last loaded into the write buffer
	logic [9:0] buf_base = '0;

	pci_master_top uut (
		.clk(clk), .rst(rst),
		.wcmd(wcmd), .wcmd_valid(wcmd_valid), .wcmd_ready(wcmd_ready),
		.wresp(wresp), .wresp_valid(wresp_valid), .wresp_ready(wresp_ready),
		.rcmd(rcmd), .rcmd_valid(rcmd_valid), .rcmd_ready(rcmd_ready),
		.rresp(rresp), .rresp_valid(rresp_valid), .rresp_ready(rresp_ready),
		.rdata_din(rdata_din), .rdata_valid(rdata_valid),
		.wbuf(wbuf), .cacheline_size(cacheline_size),
		.core(core), .adio_in(adio_in), .adio_out(adio_out),
		.request(request), .request_hold(request_hold), .m_cbe(m_cbe),
		.m_wrdn(m_wrdn), .complete(complete), .m_ready(m_ready)
	);

	pci_core_model core_model (
		.clk(clk), .request(request), .adio_in(adio_in), .m_cbe(m_cbe),
		.m_wrdn(m_wrdn), .burst_beats(burst_beats), .disc_after(disc_after),
		.no_target(no_target), .core(core), .adio_out(adio_out)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// 200 cycles per test on top of the reset
	initial begin
		int limit_ns;
		limit_ns = (16 + 200 * 6) * 8;
		#(limit_ns);
		$display("run timed out waiting for the DUT");
		$display("Errors found");
		$finish;
	end

	always @(negedge clk) begin
		if (rdata_valid)
			rd_words.push_back(rdata_din);
		if (wresp_valid && wresp_ready) begin
			last_wresp = wresp;
			wresp_cnt++;
		end
		if (rresp_valid && rresp_ready) begin
			last_rresp = rresp;
			rresp_cnt++;
		end
	end

	task automatic tick;
		@(posedge clk);
		#1;
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		$display("ERR %s got %h expected %h", name, got, exp);
		errors++;
	endtask

	task automatic finish_test(input string name, input int err_before);
		tests_run++;
		$display("test %s done, %0d failures", name, errors - err_before);
	endtask

	task automatic load_buffer(input int beats);
		logic [31:0] w;
		wwords.delete();
		for (int k = 0; k < beats; k++) begin
			w = $random(seed);
			wwords.push_back(w);
			tick();
			wbuf.we = 1'b1;
			wbuf.addr = buf_base + 10'(k);
			wbuf.data = w;
			wbuf.strb = 4'hf;
		end
		tick();
		wbuf.we = 1'b0;
	endtask

	task automatic issue_write(input logic [3:0] id, input int beats, input logic [31:0] addr);
		tick();
		wcmd.id = id;
		wcmd.len_m1 = 8'(beats - 1);
		wcmd.addr = addr;
		wcmd_valid = 1'b1;
		do tick(); while (!wcmd_ready);
		tick();
		wcmd_valid = 1'b0;
	endtask

	task automatic issue_read(input logic [3:0] id, input int beats, input logic [31:0] addr);
		tick();
		rcmd.id = id;
		rcmd.len_m1 = 8'(beats - 1);
		rcmd.addr = addr;
		rcmd_valid = 1'b1;
		do tick(); while (!rcmd_ready);
		tick();
		rcmd_valid = 1'b0;
	endtask

	task automatic write_burst(input logic [3:0] id, input int beats, input logic [31:0] addr);
		int start;
		load_buffer(beats);
		start = wresp_cnt;
		issue_write(id, beats, addr);
		while (wresp_cnt == start)
			tick();
	endtask

	task automatic read_burst(input logic [3:0] id, input int beats, input logic [31:0] addr);
		int start;
		start = rresp_cnt;
		issue_read(id, beats, addr);
		while (rresp_cnt == start)
			tick();
	endtask

	task automatic check_resp(input pci_master_pkg::pci_resp_t r, input string name,
			input logic [3:0] id, input int beats, input pci_master_pkg::resp_t err);
		checks++;
		if (r.id !== id)
			report_mismatch({name, ".id"}, 32'(r.id), 32'(id));
		if (r.len_m1 !== 8'(beats - 1))
			report_mismatch({name, ".len_m1"}, 32'(r.len_m1), 32'(beats - 1));
		if (r.err !== err)
			report_mismatch({name, ".err"}, 32'(r.err), 32'(err));
	endtask

	task automatic check_written(input logic [31:0] addr, input int beats);
		logic [31:0] got;
		for (int k = 0; k < beats; k++) begin
			got = core_model.mem[addr[9:2] + 8'(k)];
			checks++;
			if (got !== wwords[k])
				report_mismatch("target_mem", got, wwords[k]);
		end
	endtask

	task automatic check_read_data(input int first, input logic [31:0] addr, input int beats,
			input logic fill);
		logic [31:0] exp;
		checks++;
		if (rd_words.size() - first != beats)
			report_mismatch("rdata_valid_count", 32'(rd_words.size() - first), 32'(beats));
		for (int k = 0; k < beats && first + k < rd_words.size(); k++) begin
			exp = fill ? 32'hffff_ffff : core_model.mem[addr[9:2] + 8'(k)];
			checks++;
			if (rd_words[first + k] !== exp)
				report_mismatch("rdata_din", rd_words[first + k], exp);
		end
	endtask

	task automatic check_cbe(input pci_master_pkg::bus_cmd_t exp);
		checks++;
		if (core_model.last_cbe !== exp)
			report_mismatch("m_cbe", 32'(core_model.last_cbe), 32'(exp));
	endtask

	// address the target saw in the most recent address phase
	task automatic check_addr(input logic [31:0] exp);
		checks++;
		if (core_model.last_addr !== exp)
			report_mismatch("adio_in", core_model.last_addr, exp);
	endtask

	task automatic test_reset_state;
		int e0;
		e0 = errors;
		checks++;
		if (request !== 1'b0) report_mismatch("request", 32'(request), 32'h0);
		if (request_hold !== 1'b0) report_mismatch("request_hold", 32'(request_hold), 32'h0);
		if (wcmd_ready !== 1'b0) report_mismatch("wcmd_ready", 32'(wcmd_ready), 32'h0);
		if (rcmd_ready !== 1'b0) report_mismatch("rcmd_ready", 32'(rcmd_ready), 32'h0);
		if (wresp_valid !== 1'b0) report_mismatch("wresp_valid", 32'(wresp_valid), 32'h0);
		if (rresp_valid !== 1'b0) report_mismatch("rresp_valid", 32'(rresp_valid), 32'h0);
		if (rdata_valid !== 1'b0) report_mismatch("rdata_valid", 32'(rdata_valid), 32'h0);
		if (m_wrdn !== 1'b0) report_mismatch("m_wrdn", 32'(m_wrdn), 32'h0);
		if (m_ready !== 1'b1) report_mismatch("m_ready", 32'(m_ready), 32'h1);
		if (complete !== 1'b1) report_mismatch("complete", 32'(complete), 32'h1);
		finish_test("reset_state", e0);
	endtask

	task automatic test_write_burst;
		int e0;
		e0 = errors;
		burst_beats = 9'd8;
		write_burst(4'h3, 8, 32'h200);
		check_cbe(pci_master_pkg::MEM_WRITE);
		check_addr(32'h200);
		check_written(32'h200, 8);
		check_resp(last_wresp, "wresp", 4'h3, 8, pci_master_pkg::OK);
		buf_base = buf_base + 10'd8;
		finish_test("write_burst", e0);
	endtask

	task automatic read_case(input logic [3:0] id, input int beats, input logic [31:0] addr,
			input pci_master_pkg::bus_cmd_t cmd);
		int first;
		first = rd_words.size();
		burst_beats = 9'(beats);
		read_burst(id, beats, addr);
		check_cbe(cmd);
		check_addr(addr);
		check_read_data(first, addr, beats, 1'b0);
		check_resp(last_rresp, "rresp", id, beats, pci_master_pkg::OK);
	endtask

	task automatic test_read_bursts;
		int e0;
		e0 = errors;
		read_case(4'h1, 1, 32'h040, pci_master_pkg::MEM_READ);
		read_case(4'h2, 4, 32'h100, pci_master_pkg::MEM_READ_LN);
		read_case(4'h4, 4, 32'h13c, pci_master_pkg::MEM_READ_MUL); // words 79 to 82
		finish_test("read_bursts", e0);
	endtask

	task automatic test_disconnect;
		int e0;
		int reqs;
		int first;
		e0 = errors;
		burst_beats = 9'd8;
		disc_after = 9'd3;
		reqs = core_model.req_count;
		write_burst(4'h5, 8, 32'h280);
		checks++;
		if (core_model.req_count - reqs != 2)
			report_mismatch("request_count", 32'(core_model.req_count - reqs), 32'd2);
		check_addr(32'h280 + 32'd12); // second request starts at beat 3
		check_written(32'h280, 8);
		check_resp(last_wresp, "wresp", 4'h5, 8, pci_master_pkg::OK);
		buf_base = buf_base + 10'd8;
		reqs = core_model.req_count;
		first = rd_words.size();
		read_burst(4'h6, 8, 32'h300);
		checks++;
		if (core_model.req_count - reqs != 2)
			report_mismatch("request_count", 32'(core_model.req_count - reqs), 32'd2);
		check_addr(32'h300 + 32'd12);
		check_read_data(first, 32'h300, 8, 1'b0);
		check_resp(last_rresp, "rresp", 4'h6, 8, pci_master_pkg::OK);
		disc_after = 9'd0;
		finish_test("disconnect", e0);
	endtask

	task automatic test_no_target;
		int e0;
		int first;
		e0 = errors;
		no_target = 1'b1;
		write_burst(4'h7, 4, 32'h380);
		check_resp(last_wresp, "wresp", 4'h7, 4, pci_master_pkg::DECERR);
		first = rd_words.size();
		read_burst(4'h8, 5, 32'h3c0);
		check_read_data(first, 32'h3c0, 5, 1'b1);
		check_resp(last_rresp, "rresp", 4'h8, 5, pci_master_pkg::SLVERR);
		no_target = 1'b0;
		finish_test("no_target", e0);
	endtask

	task automatic test_arbitration;
		int e0;
		int ws;
		int rs;
		int first;
		logic read_first;
		e0 = errors;
		burst_beats = 9'd2;
		write_burst(4'h9, 2, 32'h3e0);
		buf_base = buf_base + 10'd2;
		load_buffer(2);
		ws = wresp_cnt;
		rs = rresp_cnt;
		first = rd_words.size();
		tick();
		wcmd.id = 4'ha;
		wcmd.len_m1 = 8'd1;
		wcmd.addr = 32'h3f0;
		rcmd.id = 4'hb;
		rcmd.len_m1 = 8'd1;
		rcmd.addr = 32'h0e0;
		wcmd_valid = 1'b1;
		rcmd_valid = 1'b1;
		do tick(); while (!wcmd_ready && !rcmd_ready);
		read_first = rcmd_ready;
		checks++;
		if (!read_first) begin
			$display("write command was accepted before the pending read");
			errors++;
		end
		tick();
		if (read_first)
			rcmd_valid = 1'b0;
		else
			wcmd_valid = 1'b0;
		while (!(read_first ? wcmd_ready : rcmd_ready))
			tick();
		tick();
		wcmd_valid = 1'b0;
		rcmd_valid = 1'b0;
		while (wresp_cnt == ws || rresp_cnt == rs)
			tick();
		check_read_data(first, 32'h0e0, 2, 1'b0);
		check_resp(last_rresp, "rresp", 4'hb, 2, pci_master_pkg::OK);
		check_written(32'h3f0, 2);
		check_resp(last_wresp, "wresp", 4'ha, 2, pci_master_pkg::OK);
		finish_test("arbitration", e0);
	endtask

	initial begin
		rst = 1'b1;
		wcmd = '0;
		rcmd = '0;
		wcmd_valid = 1'b0;
		rcmd_valid = 1'b0;
		wresp_ready = 1'b1;
		rresp_ready = 1'b1;
		wbuf = '0;
		cacheline_size = 8'd16; // words per line
		burst_beats = 9'd1;
		disc_after = 9'd0;
		no_target = 1'b0;
		repeat (16) @(posedge clk);
		#1;
		rst = 1'b0;
		tick();
		test_reset_state();
		test_write_burst();
		test_read_bursts();
		test_disconnect();
		test_no_target();
		test_arbitration();
		$display("tests %0d, checks %0d, failures %0d", tests_run, checks, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

// File: verification/pci_core_model.sv
`timescale 1ns/1ps

module pci_core_model (
	input logic clk,
	input logic request,
	input logic [31:0] adio_in,
	input logic [3:0] m_cbe,
	input logic m_wrdn,
	input logic [8:0] burst_beats,
	input logic [8:0] disc_after, // 0 means no disconnect
	input logic no_target,
	output pci_master_pkg::core_stat_t core,
	output logic [31:0] adio_out
);

	logic [31:0] mem [256];
	logic [31:0] last_addr;
	logic [3:0] last_cbe;
	int req_count;
	int remaining; // beats of the current burst not yet delivered
	int disc_left;
	int n;
	logic [7:0] widx;
	logic wr;
	logic disc;

	task automatic step;
		@(posedge clk);
		#1;
	endtask

	task automatic bus_idle;
		core.data_vld = 1'b0;
		core.src_en = 1'b0;
		core.time_out = 1'b0;
		core.data = 1'b0;
		core.addr_n = 1'b1;
		core.stopq_n = 1'b1;
	endtask

	initial begin
		for (logic [8:0] a = 0; a < 9'd256; a++)
			mem[a[7:0]] = {a[7:0], ~a[7:0], a[7:0] ^ 8'h5c, 8'hc3};
		bus_idle();
		adio_out = '0;
		last_addr = '0;
		last_cbe = '0;
		req_count = 0;
		remaining = 0;
		disc_left = 0;
		forever begin
			step();
			#2;
			if (request) begin
				step();
				step();
				core.addr_n = 1'b0; // one cycle address phase
				#2;
				last_addr = adio_in;
				last_cbe = m_cbe;
				wr = m_wrdn;
				widx = adio_in[9:2];
				req_count++;
				step();
				core.addr_n = 1'b1;
				if (no_target) begin
					core.data = 1'b1; // devsel never comes
					step();
					step();
					step();
					core.data = 1'b0;
				end else begin
					if (remaining == 0) begin
						remaining = int'(burst_beats);
						disc_left = int'(disc_after);
					end
					n = remaining;
					disc = 1'b0;
					if (disc_left != 0 && disc_left < remaining) begin
						n = disc_left;
						disc = 1'b1;
					end
					disc_left = 0;
					for (int k = 0; k < n; k++) begin
						if (k > 0)
							step();
						core.data = 1'b1;
						core.data_vld = 1'b1;
						core.src_en = wr;
						core.stopq_n = !(disc && k == n - 1);
						if (!wr)
							adio_out = mem[widx];
						#2;
						if (wr)
							mem[widx] = adio_in;
						widx++;
					end
					step();
					bus_idle();
					remaining -= n;
				end
			end
		end
	end

endmodule

// File: hw/pci_master_top.sv
`timescale 1ns/1ps

module pci_master_top (
	input logic clk,
	input logic rst,

	input pci_master_pkg::pci_cmd_t wcmd,
	input logic wcmd_valid,
	output logic wcmd_ready,
	output pci_master_pkg::pci_resp_t wresp,
	output logic wresp_valid,
	input logic wresp_ready,

	input pci_master_pkg::pci_cmd_t rcmd,
	input logic rcmd_valid,
	output logic rcmd_ready,
	output pci_master_pkg::pci_resp_t rresp,
	output logic rresp_valid,
	input logic rresp_ready,

	output logic [31:0] rdata_din,
	output logic rdata_valid,
	input pci_master_pkg::wbuf_wr_t wbuf,
	input logic [7:0] cacheline_size,

	input pci_master_pkg::core_stat_t core,
	output logic [31:0] adio_in,
	input logic [31:0] adio_out,
	output logic request,
	output logic request_hold,
	output logic [3:0] m_cbe,
	output logic m_wrdn,
	output logic complete,
	output logic m_ready
);

	pci_master_pkg::ctl_t ctl;
	pci_master_pkg::bus_cmd_t bus_cmd;
	logic fill;
	logic [8:0] write_ack_cnt;
	logic [8:0] read_ack_cnt;
	logic [31:0] write_addr;
	logic [31:0] read_addr;
	logic [8:0] read_len;
	logic [pci_master_pkg::WBUF_AW-1:0] wdata_idx;
	logic [31:0] wdata;
	logic [3:0] wstrb;

	assign m_wrdn = ctl.write_cycle;

	pci_master_fsm u_fsm (
		.clk(clk),
		.rst(rst),
		.core(core),
		.wcmd(wcmd),
		.rcmd(rcmd),
		.wcmd_valid(wcmd_valid),
		.rcmd_valid(rcmd_valid),
		.wcmd_ready(wcmd_ready),
		.rcmd_ready(rcmd_ready),
		.wresp(wresp),
		.rresp(rresp),
		.wresp_valid(wresp_valid),
		.rresp_valid(rresp_valid),
		.wresp_ready(wresp_ready),
		.rresp_ready(rresp_ready),
		.write_ack_cnt(write_ack_cnt),
		.read_ack_cnt(read_ack_cnt),
		.read_addr(read_addr),
		.read_len(read_len),
		.cacheline_size(cacheline_size),
		.ctl(ctl),
		.bus_cmd(bus_cmd),
		.fill(fill),
		.request(request),
		.request_hold(request_hold),
		.m_ready(m_ready)
	);

	pci_beat_counters u_counters (
		.clk(clk),
		.rst(rst),
		.ctl(ctl),
		.wcmd(wcmd),
		.rcmd(rcmd),
		.core(core),
		.fill(fill),
		.wresp_handshake(wresp_valid && wresp_ready),
		.write_ack_cnt(write_ack_cnt),
		.read_ack_cnt(read_ack_cnt),
		.write_addr(write_addr),
		.read_addr(read_addr),
		.read_len(read_len),
		.wdata_idx(wdata_idx),
		.complete(complete)
	);

	pci_wdata_buffer u_wbuf (
		.clk(clk),
		.wbuf(wbuf),
		.rd_idx(wdata_idx),
		.rd_data(wdata),
		.rd_strb(wstrb)
	);

	pci_adio_mux u_mux (
		.core(core),
		.write_cycle(ctl.write_cycle),
		.write_addr(write_addr),
		.read_addr(read_addr),
		.bus_cmd(bus_cmd),
		.wdata(wdata),
		.wstrb(wstrb),
		.adio_out(adio_out),
		.fill(fill),
		.adio_in(adio_in),
		.m_cbe(m_cbe),
		.rdata_din(rdata_din),
		.rdata_valid(rdata_valid)
	);

endmodule

// File: hw/pci_adio_mux.sv
`timescale 1ns/1ps

module pci_adio_mux (
	input pci_master_pkg::core_stat_t core,
	input logic write_cycle,
	input logic [31:0] write_addr,
	input logic [31:0] read_addr,
	input pci_master_pkg::bus_cmd_t bus_cmd,
	input logic [31:0] wdata,
	input logic [3:0] wstrb,
	input logic [31:0] adio_out,
	input logic fill,
	output logic [31:0] adio_in,
	output logic [3:0] m_cbe,
	output logic [31:0] rdata_din,
	output logic rdata_valid
);

	always_comb begin
		if (!core.addr_n) begin
			// address phase
			adio_in = write_cycle ? write_addr : read_addr;
			m_cbe = bus_cmd;
		end else begin
			adio_in = wdata;
			m_cbe = write_cycle ? ~wstrb : 4'b0000; // byte enables are active low on the bus
		end
	end

	assign rdata_valid = (core.data_vld && !write_cycle) || fill;
	assign rdata_din = fill ? 32'hffff_ffff : adio_out; // pad beats after a failed read

endmodule

// File: hw/pci_wdata_buffer.sv
`timescale 1ns/1ps

module pci_wdata_buffer (
	input logic clk,
	input pci_master_pkg::wbuf_wr_t wbuf,
	input logic [pci_master_pkg::WBUF_AW-1:0] rd_idx,
	output logic [31:0] rd_data,
	output logic [3:0] rd_strb
);

	logic [31:0] mem [pci_master_pkg::WBUF_DEPTH];
	logic [3:0] strb_mem [pci_master_pkg::WBUF_DEPTH]; // byte enables kept per word

	// host side, byte lanes written only where strb is set
	always_ff @(posedge clk) begin
		if (wbuf.we) begin
			for (int i = 0; i < 4; i++) begin
				if (wbuf.strb[i])
					mem[wbuf.addr][8*i +: 8] <= wbuf.data[8*i +: 8];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wbuf.we)
			strb_mem[wbuf.addr] <= wbuf.strb;
	end

	// data path side, asynchronous read by beat index
	assign rd_data = mem[rd_idx];
	assign rd_strb = strb_mem[rd_idx];

endmodule

// File: hw/pci_beat_counters.sv
`timescale 1ns/1ps

module pci_beat_counters (
	input logic clk,
	input logic rst,
	input pci_master_pkg::ctl_t ctl,
	input pci_master_pkg::pci_cmd_t wcmd,
	input pci_master_pkg::pci_cmd_t rcmd,
	input pci_master_pkg::core_stat_t core,
	input logic fill,
	input logic wresp_handshake,
	output logic [8:0] write_ack_cnt,
	output logic [8:0] read_ack_cnt,
	output logic [31:0] write_addr,
	output logic [31:0] read_addr,
	output logic [8:0] read_len,
	output logic [pci_master_pkg::WBUF_AW-1:0] wdata_idx,
	output logic complete
);

	logic read_beat;
	logic [pci_master_pkg::WBUF_AW-1:0] base_idx; // first buffer word of the current write
	logic [7:0] complete_cnt; // beats still to be acknowledged, minus one
	logic data_q;
	logic req_q; // mirrors the fsm request pulse
	logic hold_complete;
	logic gate;
	logic fin1;
	logic fin2;
	logic fin3;
	logic assert_complete;

	assign read_beat = (core.data_vld && !ctl.write_cycle) || fill;

	always_ff @(posedge clk) begin
		if (ctl.load_write) begin
			write_ack_cnt <= '0;
			write_addr <= {wcmd.addr[31:2], 2'b00};
		end else if (core.data_vld && ctl.write_cycle) begin
			write_ack_cnt <= write_ack_cnt + 9'd1;
			write_addr <= write_addr + 32'd4;
		end
	end

	always_ff @(posedge clk) begin
		if (ctl.load_read) begin
			read_ack_cnt <= '0;
			read_addr <= {rcmd.addr[31:2], 2'b00};
			read_len <= {1'b0, rcmd.len_m1} + 9'd1;
		end else if (read_beat) begin
			read_ack_cnt <= read_ack_cnt + 9'd1;
			read_addr <= read_addr + 32'd4;
			read_len <= read_len - 9'd1;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			base_idx <= '0;
		else if (wresp_handshake)
			base_idx <= base_idx + {1'b0, write_ack_cnt};
	end

	// fetch index runs ahead on src_en, a re-request rewinds it to the first unacked beat
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			wdata_idx <= '0;
		else if (ctl.reload_index)
			wdata_idx <= base_idx + {1'b0, write_ack_cnt};
		else if (core.src_en && ctl.write_cycle)
			wdata_idx <= wdata_idx + 1'b1;
	end

	always_ff @(posedge clk) begin
		if (ctl.load_write)
			complete_cnt <= wcmd.len_m1;
		else if (ctl.load_read)
			complete_cnt <= rcmd.len_m1;
		else if (core.data_vld)
			complete_cnt <= complete_cnt - 8'd1;
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			data_q <= 1'b0;
			req_q <= 1'b0;
		end else begin
			data_q <= core.data;
			req_q <= (ctl.state == pci_master_pkg::WRITE_REQ) ||
				(ctl.state == pci_master_pkg::READ_REQ);
		end
	end

	assign gate = ctl.state != pci_master_pkg::IDLE;
	assign fin1 = (complete_cnt == 8'd0) && req_q; // single beat, flag it with the request
	assign fin2 = (complete_cnt == 8'd1) && data_q;
	assign fin3 = (complete_cnt == 8'd2) && core.data_vld;
	assign assert_complete = fin1 || fin2 || fin3 || core.time_out;
	assign complete = assert_complete || hold_complete || !gate;

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			hold_complete <= 1'b0;
		else if (!core.data && data_q) // end of data phase
			hold_complete <= 1'b0;
		else if (assert_complete)
			hold_complete <= 1'b1;
	end

	assert property (@(posedge clk) disable iff (rst)
		!$stable(wdata_idx) |-> $past(ctl.write_cycle))
		else $error("wdata_idx moved outside a write");

endmodule

// File: hw/pci_master_fsm.sv
`timescale 1ns/1ps

module pci_master_fsm (
	input logic clk,
	input logic rst,
	input pci_master_pkg::core_stat_t core,
	input pci_master_pkg::pci_cmd_t wcmd,
	input pci_master_pkg::pci_cmd_t rcmd,
	input logic wcmd_valid,
	input logic rcmd_valid,
	output logic wcmd_ready,
	output logic rcmd_ready,
	output pci_master_pkg::pci_resp_t wresp,
	output pci_master_pkg::pci_resp_t rresp,
	output logic wresp_valid,
	output logic rresp_valid,
	input logic wresp_ready,
	input logic rresp_ready,
	input logic [8:0] write_ack_cnt,
	input logic [8:0] read_ack_cnt,
	input logic [31:0] read_addr,
	input logic [8:0] read_len,
	input logic [7:0] cacheline_size,
	output pci_master_pkg::ctl_t ctl,
	output pci_master_pkg::bus_cmd_t bus_cmd,
	output logic fill,
	output logic request,
	output logic request_hold,
	output logic m_ready
);

	pci_master_pkg::state_t state;
	pci_master_pkg::state_t state_next;
	logic write_cycle; // last direction, also drives M_WRDN
	logic grant; // data phase seen since the address phase
	logic strobe; // a beat was acknowledged since the address phase
	logic target_abort;
	logic write_last;
	logic read_last;
	logic read_all_acked;
	logic [29:0] first_word;
	logic [29:0] last_word;
	logic [29:0] line_mask;
	logic cross_line;

	assign write_last = core.data_vld && (write_ack_cnt == {1'b0, wresp.len_m1});
	assign read_last = core.data_vld && (read_ack_cnt == {1'b0, rresp.len_m1});
	assign read_all_acked = read_ack_cnt == {1'b0, rresp.len_m1};

	// word addresses of the first and last beat still to be read
	assign first_word = read_addr[31:2];
	assign last_word = first_word + 30'(read_len) - 30'd1;
	assign line_mask = ~(30'(cacheline_size) - 30'd1);
	assign cross_line = |((first_word ^ last_word) & line_mask);

	always_comb begin
		state_next = state;
		case (state)
			pci_master_pkg::IDLE: begin
				// the direction served last goes second
				if (write_cycle && rcmd_valid)
					state_next = pci_master_pkg::READ_INIT;
				else if (wcmd_valid)
					state_next = pci_master_pkg::WRITE_INIT;
				else if (rcmd_valid)
					state_next = pci_master_pkg::READ_INIT;
			end
			pci_master_pkg::WRITE_INIT: state_next = pci_master_pkg::WRITE_REQ;
			pci_master_pkg::WRITE_REQ: state_next = pci_master_pkg::WRITE_ADDR;
			pci_master_pkg::WRITE_ADDR:
				if (!core.addr_n)
					state_next = pci_master_pkg::WRITE_DATA;
			pci_master_pkg::WRITE_DATA: begin
				if (write_last)
					state_next = pci_master_pkg::WRITE_DONE;
				else if (target_abort)
					state_next = pci_master_pkg::WRITE_CONT;
				else if (!core.data) begin
					if (!grant) // grant lost on the first beat, core retries by itself
						state_next = pci_master_pkg::WRITE_ADDR;
					else if (strobe)
						state_next = pci_master_pkg::WRITE_CONT;
					else
						state_next = pci_master_pkg::WRITE_FAIL; // no devsel
				end
			end
			pci_master_pkg::WRITE_CONT:
				if (!core.data)
					state_next = pci_master_pkg::WRITE_REQ;
			pci_master_pkg::WRITE_DONE,
			pci_master_pkg::WRITE_FAIL:
				if (wresp_ready)
					state_next = pci_master_pkg::IDLE;
			pci_master_pkg::READ_INIT: state_next = pci_master_pkg::READ_REQ;
			pci_master_pkg::READ_REQ: state_next = pci_master_pkg::READ_ADDR;
			pci_master_pkg::READ_ADDR:
				if (!core.addr_n)
					state_next = pci_master_pkg::READ_DATA;
			pci_master_pkg::READ_DATA: begin
				if (read_last)
					state_next = pci_master_pkg::READ_DONE;
				else if (target_abort)
					state_next = pci_master_pkg::READ_CONT;
				else if (!core.data) begin
					if (!grant)
						state_next = pci_master_pkg::READ_ADDR;
					else if (strobe)
						state_next = pci_master_pkg::READ_CONT;
					else
						state_next = pci_master_pkg::READ_FILL;
				end
			end
			pci_master_pkg::READ_CONT:
				if (!core.data)
					state_next = pci_master_pkg::READ_REQ;
			pci_master_pkg::READ_FILL:
				if (read_all_acked)
					state_next = pci_master_pkg::READ_FAIL;
			pci_master_pkg::READ_DONE,
			pci_master_pkg::READ_FAIL:
				if (rresp_ready)
					state_next = pci_master_pkg::IDLE;
			default: state_next = pci_master_pkg::IDLE;
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= pci_master_pkg::IDLE;
			write_cycle <= 1'b0;
			request <= 1'b0;
			request_hold <= 1'b0;
			m_ready <= 1'b1;
			wcmd_ready <= 1'b0;
			rcmd_ready <= 1'b0;
			wresp_valid <= 1'b0;
			rresp_valid <= 1'b0;
			fill <= 1'b0;
			grant <= 1'b0;
			strobe <= 1'b0;
			target_abort <= 1'b0;
		end else begin
			state <= state_next;
			request <= 1'b0;
			wcmd_ready <= 1'b0;
			rcmd_ready <= 1'b0;
			wresp_valid <= 1'b0;
			rresp_valid <= 1'b0;
			fill <= 1'b0;
			case (state_next)
				pci_master_pkg::IDLE: begin
					request_hold <= 1'b0;
					m_ready <= 1'b1;
				end
				pci_master_pkg::WRITE_INIT: begin
					wcmd_ready <= 1'b1;
					write_cycle <= 1'b1;
				end
				pci_master_pkg::READ_INIT: begin
					rcmd_ready <= 1'b1;
					write_cycle <= 1'b0;
				end
				pci_master_pkg::WRITE_REQ,
				pci_master_pkg::READ_REQ: target_abort <= 1'b0;
				pci_master_pkg::WRITE_ADDR,
				pci_master_pkg::READ_ADDR: begin
					// pulse only when coming from REQ, not on a grant retry
					request <= (state == pci_master_pkg::WRITE_REQ) ||
						(state == pci_master_pkg::READ_REQ);
					grant <= 1'b0;
					strobe <= 1'b0;
				end
				pci_master_pkg::WRITE_DATA,
				pci_master_pkg::READ_DATA: begin
					target_abort <= target_abort || !core.stopq_n;
					grant <= grant || core.data;
					strobe <= strobe || core.data_vld;
				end
				pci_master_pkg::WRITE_DONE,
				pci_master_pkg::WRITE_FAIL: wresp_valid <= 1'b1;
				pci_master_pkg::READ_DONE,
				pci_master_pkg::READ_FAIL: rresp_valid <= 1'b1;
				pci_master_pkg::READ_FILL: fill <= 1'b1;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		case (state_next)
			pci_master_pkg::WRITE_INIT: begin
				wresp.id <= wcmd.id;
				wresp.len_m1 <= wcmd.len_m1;
			end
			pci_master_pkg::READ_INIT: begin
				rresp.id <= rcmd.id;
				rresp.len_m1 <= rcmd.len_m1;
			end
			pci_master_pkg::WRITE_ADDR: bus_cmd <= pci_master_pkg::MEM_WRITE;
			pci_master_pkg::READ_ADDR: begin
				if (read_len == 9'd1)
					bus_cmd <= pci_master_pkg::MEM_READ;
				else if (cross_line)
					bus_cmd <= pci_master_pkg::MEM_READ_MUL;
				else
					bus_cmd <= pci_master_pkg::MEM_READ_LN;
			end
			pci_master_pkg::WRITE_DONE: wresp.err <= pci_master_pkg::OK;
			pci_master_pkg::WRITE_FAIL: wresp.err <= pci_master_pkg::DECERR;
			pci_master_pkg::READ_DONE: rresp.err <= pci_master_pkg::OK;
			pci_master_pkg::READ_FAIL: rresp.err <= pci_master_pkg::SLVERR;
			default: ;
		endcase
	end

	always_comb begin
		ctl.state = state;
		ctl.load_write = state_next == pci_master_pkg::WRITE_INIT;
		ctl.load_read = state_next == pci_master_pkg::READ_INIT;
		ctl.reload_index = state_next == pci_master_pkg::WRITE_REQ;
		ctl.write_cycle = write_cycle;
	end

	assert property (@(posedge clk) disable iff (rst) request |=> !request)
		else $error("request high for two cycles");

	assert property (@(posedge clk) disable iff (rst) !(wresp_valid && rresp_valid))
		else $error("wresp_valid and rresp_valid high together");

endmodule

// File: hw/pci_master_pkg.sv
package pci_master_pkg;

	localparam int WBUF_DEPTH = 1024;
	localparam int WBUF_AW = 10;

	typedef enum logic [3:0] {
		IDLE,
		WRITE_INIT,
		WRITE_REQ,
		WRITE_ADDR,
		WRITE_DATA,
		WRITE_CONT,
		WRITE_DONE,
		WRITE_FAIL,
		READ_INIT,
		READ_REQ,
		READ_ADDR,
		READ_DATA,
		READ_CONT,
		READ_DONE,
		READ_FILL,
		READ_FAIL
	} state_t;

	// pci bus command codes on C/BE# during the address phase
	typedef enum logic [3:0] {
		MEM_READ = 4'h6,
		MEM_WRITE = 4'h7,
		MEM_READ_MUL = 4'hC,
		MEM_READ_LN = 4'hE
	} bus_cmd_t;

	typedef enum logic [1:0] {
		OK = 2'd0,
		EXOK = 2'd1,
		SLVERR = 2'd2,
		DECERR = 2'd3
	} resp_t;

	typedef struct packed {
		logic [3:0] id;
		logic [7:0] len_m1; // beats minus one
		logic [31:0] addr;
	} pci_cmd_t;

	typedef struct packed {
		logic [3:0] id;
		logic [7:0] len_m1;
		resp_t err;
	} pci_resp_t;

	// user side status of the pci core, addr_n and stopq_n stay active low
	typedef struct packed {
		logic data_vld;
		logic src_en;
		logic time_out;
		logic data;
		logic addr_n;
		logic stopq_n;
	} core_stat_t;

	typedef struct packed {
		logic we;
		logic [WBUF_AW-1:0] addr;
		logic [31:0] data;
		logic [3:0] strb;
	} wbuf_wr_t;

	// steering from the fsm to the beat counters
	typedef struct packed {
		state_t state;
		logic load_write;
		logic load_read;
		logic reload_index;
		logic write_cycle;
	} ctl_t;

endpackage
